// ==== logic/ooo_pkg.sv ====
package ooo_pkg;

    ////////////////////////////////////////
    // core sizing
    ////////////////////////////////////////
    localparam int XLEN               = 32;
    localparam int REG_NUM            = 8;   // architectural registers
    localparam int ROB_SIZE           = 8;
    localparam int RS_SIZE            = 4;   // entries per station
    localparam int MULT_BITS_PER_STEP = 2;   // radix-4 shift-add
    localparam int MULT_STEPS         = XLEN / MULT_BITS_PER_STEP;

    typedef logic [XLEN-1:0]             xlen_t;
    typedef logic [$clog2(REG_NUM)-1:0]  reg_idx_t;
    typedef logic [$clog2(ROB_SIZE)-1:0] rob_tag_t;   // doubles as rename tag
    typedef logic [4:0]                  step_cnt_t;  // holds 0..MULT_STEPS

    // decoded opcodes, everything but mul goes to the alu station
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_ADDI,
        OP_MUL
    } op_t;

    typedef enum logic [1:0] {
        MULT_IDLE,
        MULT_BUSY,
        MULT_DONE
    } mult_state_t;

endpackage

// ==== logic/mult_sequencer.sv ====
`timescale 1ns/1ps

module mult_sequencer import ooo_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        start,
    input  logic        last_step,
    input  logic        grant,
    output mult_state_t state,
    output logic        load_cnt,
    output logic        step_en
);

    mult_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            MULT_IDLE: if (start)     next_state = MULT_BUSY;
            MULT_BUSY: if (last_step) next_state = MULT_DONE;
            MULT_DONE: if (grant)     next_state = MULT_IDLE;   // result taken by cdb
            default:                  next_state = MULT_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n)
            state <= MULT_IDLE;
        else
            state <= next_state;
    end

    assign load_cnt = (state == MULT_IDLE) && start;
    assign step_en  = (state == MULT_BUSY) && !last_step;   // no step on the exit cycle

endmodule

// ==== logic/mult_step_counter.sv ====
`timescale 1ns/1ps

module mult_step_counter import ooo_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    input  logic load_cnt,
    input  logic step_en,
    output logic last_step
);

    step_cnt_t remaining;   // steps still to run

    always_ff @(posedge clock) begin
        if (!rst_n)
            remaining <= '0;
        else if (load_cnt)
            remaining <= step_cnt_t'(MULT_STEPS);
        else if (step_en)
            remaining <= remaining - 1'b1;
    end

    assign last_step = (remaining == '0);   // all steps done

endmodule

// ==== logic/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     issue,
    input  xlen_t    issue_a,
    input  xlen_t    issue_b,
    input  rob_tag_t issue_tag,
    input  logic     grant,
    output logic     busy,
    output logic     done,
    output rob_tag_t done_tag,
    output xlen_t    done_value
);

    mult_state_t state;
    logic        load_cnt, step_en, last_step;
    xlen_t       mcand, mplier;
    xlen_t       partial;   // mcand times the low multiplier bits

    mult_sequencer u_seq (
        .clock, .rst_n, .start(issue), .last_step, .grant,
        .state, .load_cnt, .step_en
    );

    mult_step_counter u_cnt (
        .clock, .rst_n, .load_cnt, .step_en, .last_step
    );

    always_comb begin
        partial = '0;
        for (int b = 0; b < MULT_BITS_PER_STEP; b++)
            if (mplier[b])
                partial = partial + (mcand << b);
    end

    // accumulator is the result register, low XLEN bits only
    always_ff @(posedge clock) begin
        if (load_cnt) begin
            mcand      <= issue_a;
            mplier     <= issue_b;
            done_tag   <= issue_tag;
            done_value <= '0;
        end else if (step_en) begin
            done_value <= done_value + partial;
            mcand      <= mcand << MULT_BITS_PER_STEP;
            mplier     <= mplier >> MULT_BITS_PER_STEP;
        end
    end

    assign done = (state == MULT_DONE);
    assign busy = (state != MULT_IDLE);   // one multiply in flight

endmodule

// ==== logic/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     issue,
    input  op_t      issue_op,
    input  xlen_t    issue_a,
    input  xlen_t    issue_b,
    input  rob_tag_t issue_tag,
    input  logic     grant,
    output logic     busy,
    output logic     done,
    output rob_tag_t done_tag,
    output xlen_t    done_value
);

    // result waits here until the bus takes it
    always_ff @(posedge clock) begin
        if (!rst_n)
            done <= 1'b0;
        else if (issue)
            done <= 1'b1;   // back to back when granted
        else if (grant)
            done <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            done_tag <= issue_tag;
            case (issue_op)
                OP_SUB:  done_value <= issue_a - issue_b;
                OP_XOR:  done_value <= issue_a ^ issue_b;
                default: done_value <= issue_a + issue_b;   // add and addi
            endcase
        end
    end

    assign busy = done && !grant;

endmodule

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     load,
    input  op_t      op,
    input  xlen_t    v1,
    input  xlen_t    v2,
    input  logic     rdy1,
    input  logic     rdy2,
    input  rob_tag_t t1,
    input  rob_tag_t t2,
    input  rob_tag_t dst,
    input  logic     unit_busy,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  xlen_t    cdb_value,
    output logic     full,
    output logic     issue,
    output op_t      issue_op,
    output xlen_t    issue_a,
    output xlen_t    issue_b,
    output rob_tag_t issue_tag
);

    logic     ent_valid [RS_SIZE];
    op_t      ent_op    [RS_SIZE];
    xlen_t    ent_v1    [RS_SIZE];
    xlen_t    ent_v2    [RS_SIZE];
    logic     ent_rdy1  [RS_SIZE];
    logic     ent_rdy2  [RS_SIZE];
    rob_tag_t ent_t1    [RS_SIZE];
    rob_tag_t ent_t2    [RS_SIZE];
    rob_tag_t ent_dst   [RS_SIZE];
    logic [$clog2(RS_SIZE)-1:0] ent_age [RS_SIZE];   // count of younger live entries

    logic [$clog2(RS_SIZE)-1:0] pick;   // oldest ready entry
    logic [$clog2(RS_SIZE)-1:0] slot;   // first free entry
    logic any_ready, any_free;

    ////////////////////////////////////////
    // select
    ////////////////////////////////////////
    always_comb begin
        any_ready = 1'b0;
        pick      = '0;
        any_free  = 1'b0;
        slot      = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (ent_valid[i] && ent_rdy1[i] && ent_rdy2[i] &&
                (!any_ready || ent_age[i] > ent_age[pick])) begin
                any_ready = 1'b1;
                pick      = ($clog2(RS_SIZE))'(i);
            end
            if (!ent_valid[i] && !any_free) begin
                any_free = 1'b1;
                slot     = ($clog2(RS_SIZE))'(i);
            end
        end
    end

    assign full      = !any_free;
    assign issue     = any_ready && !unit_busy;   // held off while unit has a result
    assign issue_op  = ent_op[pick];
    assign issue_a   = ent_v1[pick];
    assign issue_b   = ent_v2[pick];
    assign issue_tag = ent_dst[pick];

    ////////////////////////////////////////
    // entry update
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < RS_SIZE; i++)
                ent_valid[i] <= 1'b0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (ent_valid[i]) begin
                    // tag wakeup from the bus
                    if (!ent_rdy1[i] && cdb_valid && ent_t1[i] == cdb_tag) begin
                        ent_v1[i]   <= cdb_value;
                        ent_rdy1[i] <= 1'b1;
                    end
                    if (!ent_rdy2[i] && cdb_valid && ent_t2[i] == cdb_tag) begin
                        ent_v2[i]   <= cdb_value;
                        ent_rdy2[i] <= 1'b1;
                    end
                    // younger arrives vs younger leaves
                    if (load && !(issue && ent_age[i] > ent_age[pick]))
                        ent_age[i] <= ent_age[i] + 1'b1;
                    else if (!load && issue && ent_age[i] > ent_age[pick])
                        ent_age[i] <= ent_age[i] - 1'b1;
                end
            end
            if (issue)
                ent_valid[pick] <= 1'b0;
            if (load) begin
                ent_valid[slot] <= 1'b1;
                ent_op[slot]    <= op;
                ent_v1[slot]    <= v1;
                ent_v2[slot]    <= v2;
                ent_rdy1[slot]  <= rdy1;
                ent_rdy2[slot]  <= rdy2;
                ent_t1[slot]    <= t1;
                ent_t2[slot]    <= t2;
                ent_dst[slot]   <= dst;
                ent_age[slot]   <= '0;   // youngest
            end
        end
    end

endmodule

// ==== logic/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     alu_done,
    input  rob_tag_t alu_tag,
    input  xlen_t    alu_value,
    input  logic     mult_done,
    input  rob_tag_t mult_tag,
    input  xlen_t    mult_value,
    output logic     alu_grant,
    output logic     mult_grant,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output xlen_t    cdb_value
);

    logic mult_last;   // mult held the bus last time

    // on a tie the previous loser goes first
    assign alu_grant  = alu_done && (!mult_done || mult_last);
    assign mult_grant = mult_done && !alu_grant;

    assign cdb_valid = alu_grant || mult_grant;
    assign cdb_tag   = alu_grant ? alu_tag : mult_tag;
    assign cdb_value = alu_grant ? alu_value : mult_value;

    always_ff @(posedge clock) begin
        if (!rst_n)
            mult_last <= 1'b0;
        else if (alu_grant)
            mult_last <= 1'b0;
        else if (mult_grant)
            mult_last <= 1'b1;
    end

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     alloc,
    input  reg_idx_t alloc_dst,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  xlen_t    cdb_value,
    input  rob_tag_t query1,
    input  rob_tag_t query2,
    output rob_tag_t free_tag,
    output logic     full,
    output logic     done1,
    output logic     done2,
    output xlen_t    value1,
    output xlen_t    value2,
    output logic     retire_en,
    output reg_idx_t retire_idx,
    output rob_tag_t retire_tag,
    output xlen_t    retire_data,
    output logic     commit_valid,
    output reg_idx_t commit_idx,
    output xlen_t    commit_data
);

    reg_idx_t ent_dst   [ROB_SIZE];
    logic     ent_done  [ROB_SIZE];
    xlen_t    ent_value [ROB_SIZE];
    rob_tag_t head, tail;
    logic [$clog2(ROB_SIZE+1)-1:0] count;   // live entries

    assign free_tag = tail;
    assign full     = (count == ROB_SIZE);

    // operand lookups for dispatch
    assign done1  = ent_done[query1];
    assign done2  = ent_done[query2];
    assign value1 = ent_value[query1];
    assign value2 = ent_value[query2];

    // in order, one per cycle
    assign retire_en   = (count != '0) && ent_done[head];
    assign retire_idx  = ent_dst[head];
    assign retire_tag  = head;
    assign retire_data = ent_value[head];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < ROB_SIZE; i++)
                ent_done[i] <= 1'b0;
        end else begin
            if (alloc) begin
                ent_dst[tail]  <= alloc_dst;
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;   // wraps at ROB_SIZE
            end
            if (cdb_valid) begin   // completion
                ent_done[cdb_tag]  <= 1'b1;
                ent_value[cdb_tag] <= cdb_value;
            end
            if (retire_en)
                head <= head + 1'b1;
            case ({alloc, retire_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commit_valid <= retire_en;   // registered report
        end
    end

    always_ff @(posedge clock) begin
        commit_idx  <= retire_idx;
        commit_data <= retire_data;
    end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  xlen_t    wdata,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [REG_NUM];   // committed state only

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++)
                regs[i] <= '0;
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];   // async read
    assign rdata2 = regs[raddr2];

endmodule

// ==== logic/dispatch_rename.sv ====
`timescale 1ns/1ps

module dispatch_rename import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     inst_valid,
    input  op_t      inst_op,
    input  reg_idx_t inst_dst,
    input  reg_idx_t inst_src1,
    input  reg_idx_t inst_src2,
    input  xlen_t    inst_imm,
    input  rob_tag_t free_tag,
    input  logic     rob_full,
    input  logic     alu_full,
    input  logic     mult_full,
    input  xlen_t    reg_rdata1,
    input  xlen_t    reg_rdata2,
    input  logic     rob_done1,
    input  logic     rob_done2,
    input  xlen_t    rob_value1,
    input  xlen_t    rob_value2,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  xlen_t    cdb_value,
    input  logic     retire_en,
    input  reg_idx_t retire_idx,
    input  rob_tag_t retire_tag,
    output logic     inst_ready,
    output logic     rob_alloc,
    output reg_idx_t alloc_dst,
    output reg_idx_t reg_raddr1,
    output reg_idx_t reg_raddr2,
    output rob_tag_t rob_query1,
    output rob_tag_t rob_query2,
    output logic     alu_load,
    output logic     mult_load,
    output op_t      rs_op,
    output xlen_t    rs_v1,
    output xlen_t    rs_v2,
    output logic     rs_rdy1,
    output logic     rs_rdy2,
    output rob_tag_t rs_t1,
    output rob_tag_t rs_t2,
    output rob_tag_t rs_dst
);

    logic     ren_busy [REG_NUM];   // register waits on a rob entry
    rob_tag_t ren_tag  [REG_NUM];
    logic     running;              // low through reset and one cycle after
    logic     is_mul;
    logic     fire;

    // regfile, then finished rob entry, then live cdb, else wait on tag
    function automatic logic [XLEN:0] fetch_operand(input logic renamed,
                                                    input rob_tag_t tag,
                                                    input xlen_t rf_val,
                                                    input logic rob_done,
                                                    input xlen_t rob_val);
        if (!renamed)
            return {1'b1, rf_val};
        if (rob_done)
            return {1'b1, rob_val};
        if (cdb_valid && cdb_tag == tag)
            return {1'b1, cdb_value};   // producer broadcasting right now
        return {1'b0, rf_val};          // value ignored until wakeup
    endfunction

    assign is_mul     = (inst_op == OP_MUL);
    assign inst_ready = running && !rob_full && !(is_mul ? mult_full : alu_full);
    assign fire       = inst_valid && inst_ready;

    assign rob_alloc  = fire;
    assign alloc_dst  = inst_dst;
    assign alu_load   = fire && !is_mul;
    assign mult_load  = fire && is_mul;

    assign reg_raddr1 = inst_src1;
    assign reg_raddr2 = inst_src2;
    assign rob_query1 = ren_tag[inst_src1];
    assign rob_query2 = ren_tag[inst_src2];

    assign rs_op  = inst_op;
    assign rs_t1  = ren_tag[inst_src1];
    assign rs_t2  = ren_tag[inst_src2];
    assign rs_dst = free_tag;   // rob slot is the new name

    assign {rs_rdy1, rs_v1} = fetch_operand(ren_busy[inst_src1], ren_tag[inst_src1],
                                            reg_rdata1, rob_done1, rob_value1);
    assign {rs_rdy2, rs_v2} = (inst_op == OP_ADDI) ? {1'b1, inst_imm} :
                              fetch_operand(ren_busy[inst_src2], ren_tag[inst_src2],
                                            reg_rdata2, rob_done2, rob_value2);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            running <= 1'b0;
            for (int i = 0; i < REG_NUM; i++)
                ren_busy[i] <= 1'b0;
        end else begin
            running <= 1'b1;
            // drop mapping once its producer retires
            if (retire_en && ren_tag[retire_idx] == retire_tag)
                ren_busy[retire_idx] <= 1'b0;
            if (fire) begin   // a new rename wins over the retire clear
                ren_busy[inst_dst] <= 1'b1;
                ren_tag[inst_dst]  <= free_tag;
            end
        end
    end

endmodule

// ==== logic/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     inst_valid,
    input  op_t      inst_op,
    input  reg_idx_t inst_dst,
    input  reg_idx_t inst_src1,
    input  reg_idx_t inst_src2,
    input  xlen_t    inst_imm,
    output logic     inst_ready,
    output logic     commit_valid,
    output reg_idx_t commit_idx,
    output xlen_t    commit_data
);

    ////////////////////////////////////////
    // dispatch
    ////////////////////////////////////////
    rob_tag_t free_tag;
    logic     rob_full, alu_full, mult_full;
    xlen_t    reg_rdata1, reg_rdata2;
    logic     rob_done1, rob_done2;
    xlen_t    rob_value1, rob_value2;
    logic     rob_alloc;
    reg_idx_t alloc_dst;
    reg_idx_t reg_raddr1, reg_raddr2;
    rob_tag_t rob_query1, rob_query2;
    logic     alu_load, mult_load;
    op_t      rs_op;                        // shared entry fields to both stations
    xlen_t    rs_v1, rs_v2;
    logic     rs_rdy1, rs_rdy2;
    rob_tag_t rs_t1, rs_t2, rs_dst;

    // common data bus and retire
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    xlen_t    cdb_value;
    logic     retire_en;
    reg_idx_t retire_idx;
    rob_tag_t retire_tag;
    xlen_t    retire_data;

    dispatch_rename u_dispatch (
        .clock, .rst_n,
        .inst_valid, .inst_op, .inst_dst, .inst_src1, .inst_src2, .inst_imm,
        .free_tag, .rob_full, .alu_full, .mult_full,
        .reg_rdata1, .reg_rdata2, .rob_done1, .rob_done2, .rob_value1, .rob_value2,
        .cdb_valid, .cdb_tag, .cdb_value, .retire_en, .retire_idx, .retire_tag,
        .inst_ready, .rob_alloc, .alloc_dst, .reg_raddr1, .reg_raddr2,
        .rob_query1, .rob_query2, .alu_load, .mult_load,
        .rs_op, .rs_v1, .rs_v2, .rs_rdy1, .rs_rdy2, .rs_t1, .rs_t2, .rs_dst
    );

    ////////////////////////////////////////
    // issue and execute
    ////////////////////////////////////////
    logic     alu_issue, alu_busy, alu_done, alu_grant;
    op_t      alu_issue_op;
    xlen_t    alu_a, alu_b, alu_value;
    rob_tag_t alu_issue_tag, alu_tag;
    logic     mult_issue, mult_busy, mult_done, mult_grant;
    xlen_t    mult_a, mult_b, mult_value;
    rob_tag_t mult_issue_tag, mult_tag;

    reservation_station u_rs_alu (
        .clock, .rst_n, .load(alu_load),
        .op(rs_op), .v1(rs_v1), .v2(rs_v2), .rdy1(rs_rdy1), .rdy2(rs_rdy2),
        .t1(rs_t1), .t2(rs_t2), .dst(rs_dst), .unit_busy(alu_busy),
        .cdb_valid, .cdb_tag, .cdb_value,
        .full(alu_full), .issue(alu_issue), .issue_op(alu_issue_op),
        .issue_a(alu_a), .issue_b(alu_b), .issue_tag(alu_issue_tag)
    );

    reservation_station u_rs_mult (
        .clock, .rst_n, .load(mult_load),
        .op(rs_op), .v1(rs_v1), .v2(rs_v2), .rdy1(rs_rdy1), .rdy2(rs_rdy2),
        .t1(rs_t1), .t2(rs_t2), .dst(rs_dst), .unit_busy(mult_busy),
        .cdb_valid, .cdb_tag, .cdb_value,
        .full(mult_full), .issue(mult_issue), .issue_op(),   // only one op here
        .issue_a(mult_a), .issue_b(mult_b), .issue_tag(mult_issue_tag)
    );

    alu_unit u_alu (
        .clock, .rst_n, .issue(alu_issue), .issue_op(alu_issue_op),
        .issue_a(alu_a), .issue_b(alu_b), .issue_tag(alu_issue_tag), .grant(alu_grant),
        .busy(alu_busy), .done(alu_done), .done_tag(alu_tag), .done_value(alu_value)
    );

    mult_unit u_mult (
        .clock, .rst_n, .issue(mult_issue),
        .issue_a(mult_a), .issue_b(mult_b), .issue_tag(mult_issue_tag), .grant(mult_grant),
        .busy(mult_busy), .done(mult_done), .done_tag(mult_tag), .done_value(mult_value)
    );

    ////////////////////////////////////////
    // complete and retire
    ////////////////////////////////////////
    cdb_arbiter u_cdb (
        .clock, .rst_n,
        .alu_done, .alu_tag, .alu_value, .mult_done, .mult_tag, .mult_value,
        .alu_grant, .mult_grant, .cdb_valid, .cdb_tag, .cdb_value
    );

    reorder_buffer u_rob (
        .clock, .rst_n, .alloc(rob_alloc), .alloc_dst,
        .cdb_valid, .cdb_tag, .cdb_value, .query1(rob_query1), .query2(rob_query2),
        .free_tag, .full(rob_full), .done1(rob_done1), .done2(rob_done2),
        .value1(rob_value1), .value2(rob_value2),
        .retire_en, .retire_idx, .retire_tag, .retire_data,
        .commit_valid, .commit_idx, .commit_data
    );

    register_file u_regfile (
        .clock, .rst_n, .raddr1(reg_raddr1), .raddr2(reg_raddr2),
        .wen(retire_en), .waddr(retire_idx), .wdata(retire_data),   // written at retire
        .rdata1(reg_rdata1), .rdata2(reg_rdata2)
    );

endmodule

// ==== verification/ooo_core_tb.sv ====
`timescale 1ns/1ps

module ooo_core_tb import ooo_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_ALU        = 60;
    localparam int N_MIX        = 40;
    localparam int N_CHAIN      = 30;
    localparam int N_LOADS      = 8;    // addi preloads before the burst
    localparam int N_BURST      = 24;
    localparam int TOTAL_INSTS  = 1 + N_ALU + N_MIX + N_CHAIN + N_LOADS + N_BURST;
    localparam int WATCHDOG_NS  = (TOTAL_INSTS * (MULT_STEPS + 8) + 40) * CLK_PERIOD;

    logic     clock;
    logic     rst_n;
    logic     inst_valid;
    op_t      inst_op;
    reg_idx_t inst_dst, inst_src1, inst_src2;
    xlen_t    inst_imm;
    logic     inst_ready;
    logic     commit_valid;
    reg_idx_t commit_idx;
    xlen_t    commit_data;

    // reference model state
    xlen_t       model_regs [REG_NUM];
    reg_idx_t    exp_idx  [$];
    xlen_t       exp_data [$];
    string       exp_name [$];
    logic        stall_seen;   // inst_ready seen low while valid
    logic [31:0] rng_state;

    ooo_core u_dut (
        .clock, .rst_n, .inst_valid, .inst_op, .inst_dst, .inst_src1, .inst_src2,
        .inst_imm, .inst_ready, .commit_valid, .commit_idx, .commit_data
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped on first failure");
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act)
            fail_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act)
            fail_run($sformatf("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("[ERROR] %s expected %0b actual %0b", name, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // architectural result of one instruction
    function automatic xlen_t model_result(input op_t op, input xlen_t a, input xlen_t b,
                                           input xlen_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + imm;
            default: return a * b;   // low 32 bits of the product
        endcase
    endfunction

    // hold the instruction until accepted, then step the model
    task automatic send_inst(input string name, input op_t op, input reg_idx_t dst,
                             input reg_idx_t src1, input reg_idx_t src2, input xlen_t imm);
        logic  taken;
        xlen_t result;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clock);
            inst_valid = 1'b1;
            inst_op    = op;
            inst_dst   = dst;
            inst_src1  = src1;
            inst_src2  = src2;
            inst_imm   = imm;
            #1;               // settled, well before the rising edge
            taken = inst_ready;
            if (!taken)
                stall_seen = 1'b1;
            @(posedge clock);
        end
        result = model_result(op, model_regs[src1], model_regs[src2], imm);
        model_regs[dst] = result;
        exp_idx.push_back(dst);
        exp_data.push_back(result);
        exp_name.push_back(name);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            inst_valid = 1'b0;
        end
    endtask

    task automatic send_random(input string name, input logic allow_mul, input logic gaps);
        logic [31:0] r;
        logic [31:0] imm;
        op_t         op;
        draw(r);
        draw(imm);
        op = op_t'({1'b0, r[1:0]});
        if (allow_mul && r[3:2] == 2'b00)
            op = OP_MUL;
        send_inst(name, op, r[6:4], r[9:7], r[12:10], imm);
        if (gaps && r[31:30] == 2'b00)
            idle(1 + r[29]);   // short valid gap
    endtask

    ////////////////////////////////////////
    // commit monitor
    ////////////////////////////////////////
    always @(negedge clock) begin
        if (rst_n && commit_valid) begin
            if (exp_idx.size() == 0) begin
                fail_run("commit seen with no accepted instruction outstanding");
            end else begin
                check_idx({exp_name[0], " idx"}, exp_idx[0], commit_idx);
                check_data({exp_name[0], " data"}, exp_data[0], commit_data);
                void'(exp_idx.pop_front());
                void'(exp_data.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all instructions committed");
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        logic [31:0] r;
        int          waited;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst_op      = OP_ADD;
        inst_dst     = '0;
        inst_src1    = '0;
        inst_src2    = '0;
        inst_imm     = '0;
        rng_state    = 32'd41130;
        stall_seen   = 1'b0;
        for (int i = 0; i < REG_NUM; i++)
            model_regs[i] = '0;

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        check_flag("reset inst_ready", 1'b0, inst_ready);
        check_flag("reset commit_valid", 1'b0, commit_valid);
        rst_n = 1'b1;

        waited = 0;
        while (!inst_ready && waited < 10) begin
            @(negedge clock);
            waited++;
        end
        check_flag("reset_zero inst_ready", 1'b1, inst_ready);
        send_inst("reset_zero", OP_ADD, 3'd1, 3'd2, 3'd3, 32'h0);   // unset regs give 0

        for (int i = 0; i < N_ALU; i++)
            send_random("alu_random", 1'b0, 1'b1);
        for (int i = 0; i < N_MIX; i++)
            send_random("mul_mix", 1'b1, 1'b1);

        // same register as dst and src1, back to back
        for (int i = 0; i < N_CHAIN; i++) begin
            draw(r);
            send_inst("dep_chain", (r[3:0] == 4'd0) ? OP_MUL : op_t'({1'b0, r[1:0]}),
                      3'd5, 3'd5, r[2] ? 3'd5 : r[6:4], {16'h0, r[31:16]});
        end

        for (int i = 0; i < N_LOADS; i++) begin
            draw(r);
            send_inst("mul_burst", OP_ADDI, reg_idx_t'(i), reg_idx_t'(i), 3'd0, r);
        end
        stall_seen = 1'b0;
        for (int i = 0; i < N_BURST; i++) begin
            draw(r);
            send_inst("mul_burst", OP_MUL, r[2:0], r[5:3], r[8:6], 32'h0);
        end
        idle(1);
        check_flag("mul_burst inst_ready drop", 1'b1, stall_seen);

        // drain, then leave room for stray commits
        waited = 0;
        while (exp_idx.size() != 0 && waited < TOTAL_INSTS * (MULT_STEPS + 2)) begin
            @(negedge clock);
            waited++;
        end
        repeat (20) @(negedge clock);

        if (exp_idx.size() != 0)
            fail_run($sformatf("%0d accepted instructions never committed", exp_idx.size()));
        else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
logic/ooo_pkg.sv
logic/mult_sequencer.sv
logic/mult_step_counter.sv
logic/mult_unit.sv
logic/alu_unit.sv
logic/reservation_station.sv
logic/cdb_arbiter.sv
logic/reorder_buffer.sv
logic/register_file.sv
logic/dispatch_rename.sv
logic/ooo_core.sv
verification/ooo_core_tb.sv

// ==== Makefile ====
# Verilator build of the out-of-order core testbench
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal
EXTRA     ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
